/* flist.f */
hw/mod_pkg.sv
hw/mod_csr.sv
hw/mod_square_gen.sv
hw/mod_demod.sv
hw/mod_top.sv
dv/mod_tb.sv

/* dv/mod_tb.sv */
// Bias modulator testbench
module mod_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mod_pkg::*;

    localparam int NUM_HP           = 5;
    localparam int PERIODS_PER_TEST = 6;
    localparam int BUS_TIMEOUT      = 16;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    adc_t        adc;
    amp_t        dac;
    logic        level;
    adc_t        adc_high;
    adc_t        adc_low;
    logic [31:0] rng_state = 32'h022920e2;
    hperiod_t    hp [NUM_HP];
    int          watchdog_cycles;

    mod_top u_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .i_adc    (adc),
        .o_dac    (dac),
        .o_level  (level)
    );

    // The ADC sees the level of the same cycle, like a sensor with no delay.
    assign adc = level ? adc_high : adc_low;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic wb_data_t ctrl_word(input skip_t skip, input logic en);
        wb_data_t w;
        w       = '0;
        w[0]    = en;
        w[15:8] = skip;
        return w;
    endfunction

    function automatic wb_data_t amp_word(input amp_t a);
        return {16'h0000, a};
    endfunction

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "Stopping on the first failure.");
    endtask

    task automatic check_amp(input string name, input amp_t exp, input amp_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_acc(input string name, input acc_t exp, input acc_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                              output wb_data_t rdat);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (wb_ack !== 1'b1 && n < BUS_TIMEOUT);
        if (wb_ack !== 1'b1) begin
            $display("Bus access to address %0d got no acknowledge.", adr);
            stop_with_failure();
        end
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic configure(input hperiod_t h, input amp_t hi, input amp_t lo);
        wb_write(REG_CTRL, ctrl_word('0, 1'b0));
        wb_write(REG_HPERIOD, wb_data_t'(h));
        wb_write(REG_AMP_HIGH, amp_word(hi));
        wb_write(REG_AMP_LOW, amp_word(lo));
    endtask

    task automatic wait_level_change(input string name, input hperiod_t h);
        logic start;
        int   n;
        start = level;
        n     = 0;
        do begin
            @(posedge clk);
            n++;
        end while (level == start && n < 4 * (h + 1) + 16);
        if (level == start) begin
            $display("The level output never changed during %s.", name);
            stop_with_failure();
        end
    endtask

    // Counts the samples of one level run and checks the DAC word on each.
    task automatic measure_run(input string name, input logic exp_level, input amp_t hi,
                               input amp_t lo, input hperiod_t h, output int len);
        amp_t exp_dac;
        exp_dac = exp_level ? hi : lo;
        len     = 0;
        check_word(name, wb_data_t'(exp_level), wb_data_t'(level));
        while (level == exp_level && len <= 4 * (h + 1) + 16) begin
            check_amp(name, exp_dac, dac);
            @(posedge clk);
            len++;
        end
        if (level == exp_level) begin
            $display("A level run never ended during %s.", name);
            stop_with_failure();
        end
    endtask

    task automatic wait_result_count(input string name, input int target, input hperiod_t h);
        wb_data_t cnt;
        int       n;
        n = 0;
        do begin
            wb_read(REG_RESULT_CNT, cnt);
            n++;
        end while (cnt < target && n < 2 * (h + 1) * (target + 1));
        if (cnt < target) begin
            $display("The result count stayed at %0d in %s, waiting for %0d.", cnt, name, target);
            stop_with_failure();
        end
    endtask

    task automatic test_registers();
        hperiod_t h;
        amp_t     hi;
        amp_t     lo;
        wb_data_t rd;
        h  = hperiod_t'(next_random());
        hi = amp_t'(next_random());
        lo = amp_t'(next_random());
        wb_write(REG_CTRL, ctrl_word(8'h5a, 1'b0));
        wb_read(REG_CTRL, rd);
        check_word("registers ctrl", ctrl_word(8'h5a, 1'b0), rd);
        wb_write(REG_HPERIOD, wb_data_t'(h));
        wb_read(REG_HPERIOD, rd);
        check_word("registers half period", wb_data_t'(h), rd);
        wb_write(REG_AMP_HIGH, amp_word(hi));
        wb_read(REG_AMP_HIGH, rd);
        check_word("registers amp high", amp_word(hi), rd);
        wb_write(REG_AMP_LOW, amp_word(lo));
        wb_read(REG_AMP_LOW, rd);
        check_word("registers amp low", amp_word(lo), rd);
        wb_write(REG_RESULT, 32'hdeadbeef);
        wb_read(REG_RESULT, rd);
        check_word("registers result read only", '0, rd);
        wb_write(REG_RESULT_CNT, 32'h12345678);
        wb_read(REG_RESULT_CNT, rd);
        check_word("registers count read only", '0, rd);
        wb_write(4'd9, 32'hffffffff);
        wb_read(4'd9, rd);
        check_word("registers unmapped", '0, rd);
    endtask

    task automatic test_idle();
        amp_t hi;
        amp_t lo;
        hi = amp_t'(next_random());
        lo = amp_t'(next_random());
        configure(hperiod_t'(5), hi, lo);
        repeat (4) @(posedge clk);
        repeat (20) begin
            @(posedge clk);
            check_amp("idle dac", lo, dac);
            check_word("idle level", '0, wb_data_t'(level));
        end
    endtask

    task automatic test_square_wave(input hperiod_t h);
        amp_t hi;
        amp_t lo;
        int   len;
        logic exp_level;
        hi = amp_t'(next_random());
        lo = amp_t'(next_random());
        configure(h, hi, lo);
        wb_write(REG_CTRL, ctrl_word('0, 1'b1));
        wait_level_change("square wave", h);
        // The first change after enable ends the opening low phase.
        exp_level = 1'b1;
        repeat (4) begin
            measure_run("square wave dac", exp_level, hi, lo, h, len);
            check_word("square wave run length", wb_data_t'(h + 1), wb_data_t'(len));
            exp_level = !exp_level;
        end
        wb_write(REG_CTRL, ctrl_word('0, 1'b0));
    endtask

    task automatic test_demod(input string name, input hperiod_t h, input skip_t k);
        adc_t     vh;
        adc_t     vl;
        acc_t     exp;
        wb_data_t rd;
        vh = adc_t'(next_random());
        vl = adc_t'(next_random());
        adc_high <= vh;
        adc_low  <= vl;
        configure(h, amp_t'(next_random()), amp_t'(next_random()));
        exp = acc_t'((int'(h) + 1 - int'(k)) * (int'(vh) - int'(vl)));
        wb_write(REG_CTRL, ctrl_word(k, 1'b1));
        wait_result_count(name, 1, h);
        wb_read(REG_RESULT, rd);
        check_acc(name, exp, acc_t'(rd));
        wait_result_count(name, 3, h);
        wb_read(REG_RESULT, rd);
        check_acc(name, exp, acc_t'(rd));
        wb_write(REG_CTRL, ctrl_word('0, 1'b0));
    endtask

    task automatic test_hperiod_change(input hperiod_t h1, input hperiod_t h2);
        amp_t     hi;
        amp_t     lo;
        int       len;
        wb_data_t rd;
        logic     exp_level;
        hi = amp_t'(next_random());
        lo = amp_t'(next_random());
        configure(h1, hi, lo);
        wb_write(REG_CTRL, ctrl_word('0, 1'b1));
        wait_level_change("half period change", h1);
        measure_run("half period change dac", 1'b1, hi, lo, h1, len);
        check_word("half period before change", wb_data_t'(h1 + 1), wb_data_t'(len));
        wb_write(REG_HPERIOD, wb_data_t'(h2));
        // The phase running at the write may still use the old count.
        wait_level_change("half period change", h1 > h2 ? h1 : h2);
        wait_level_change("half period change", h1 > h2 ? h1 : h2);
        exp_level = 1'b0;
        repeat (2) begin
            measure_run("half period change dac", exp_level, hi, lo, h2, len);
            check_word("half period after change", wb_data_t'(h2 + 1), wb_data_t'(len));
            exp_level = !exp_level;
        end
        wb_write(REG_CTRL, ctrl_word('0, 1'b0));
        repeat (4) @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            check_amp("disable dac", lo, dac);
            check_word("disable level", '0, wb_data_t'(level));
        end
        wb_read(REG_RESULT_CNT, rd);
        check_word("disable result count", '0, rd);
    endtask

    initial begin
        int periods;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        adc_high = '0;
        adc_low  = '0;
        periods  = 0;
        for (int i = 0; i < NUM_HP; i++) begin
            hp[i]   = hperiod_t'(3 + next_random() % 16);
            periods = periods + 2 * (hp[i] + 1) * PERIODS_PER_TEST;
        end
        watchdog_cycles = 4 * periods + 3000;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_registers();
        test_idle();
        test_square_wave(hp[0]);
        test_demod("demod skip 0", hp[1], '0);
        test_demod("demod with skip", hp[2], skip_t'(1 + next_random() % hp[2]));
        test_hperiod_change(hp[3], hp[4]);

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #1;
        repeat (watchdog_cycles) @(posedge clk);
        $display("Simulation timed out after %0d clock cycles.", watchdog_cycles);
        stop_with_failure();
    end

endmodule

/* hw/mod_top.sv */
// Bias modulator top level
module mod_top (
    input  logic              i_clk,
    input  logic              i_rst_n,

    // Wishbone classic slave
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  mod_pkg::wb_addr_t i_wb_adr,
    input  mod_pkg::wb_data_t i_wb_dat,
    output mod_pkg::wb_data_t o_wb_dat,
    output logic              o_wb_ack,

    // Converter side on i_clk
    input  mod_pkg::adc_t     i_adc,
    output mod_pkg::amp_t     o_dac,
    output logic              o_level
);
    import mod_pkg::*;

    mod_cfg_t   cfg;
    mod_phase_t phase;
    demod_res_t res;

    mod_csr u_csr (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_res    (res),
        .o_cfg    (cfg)
    );

    mod_square_gen u_gen (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cfg   (cfg),
        .o_phase (phase),
        .o_dac   (o_dac)
    );

    // The demodulator sees the same registered phase as the DAC word.
    mod_demod u_demod (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cfg   (cfg),
        .i_phase (phase),
        .i_adc   (i_adc),
        .o_res   (res)
    );

    // Level doubles as the sync output for external equipment.
    assign o_level = phase.level;

endmodule

/* hw/mod_demod.sv */
// Synchronous square-wave demodulator
module mod_demod (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mod_pkg::mod_cfg_t   i_cfg,
    input  mod_pkg::mod_phase_t i_phase,
    input  mod_pkg::adc_t       i_adc,
    output mod_pkg::demod_res_t o_res
);
    import mod_pkg::*;

    // Set from the first step after enable until enable drops.
    logic  run_q;
    skip_t settle_q;
    acc_t  acc_q;

    logic  in_phase;
    skip_t settle_now;
    logic  accept;
    logic  dump;
    acc_t  samp_ext;
    acc_t  contrib;
    acc_t  acc_d;

    always_comb begin
        in_phase = i_phase.step || run_q;

        // A step restarts the settling window with the current sample as
        // the first one of the phase.
        settle_now = i_phase.step ? i_cfg.skip : settle_q;
        accept     = in_phase && (settle_now == '0);

        samp_ext = acc_t'(i_adc);
        contrib  = '0;
        if (accept) begin
            contrib = i_phase.level ? samp_ext : -samp_ext;
        end

        // A low step after a high phase closes one full period.
        dump  = i_cfg.enable && i_phase.step && !i_phase.level && run_q;
        acc_d = dump ? contrib : acc_q + contrib;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q    <= 1'b0;
            settle_q <= '0;
            acc_q    <= '0;
        end else if (!i_cfg.enable) begin
            run_q    <= 1'b0;
            settle_q <= '0;
            acc_q    <= '0;
        end else begin
            run_q <= in_phase;
            if (in_phase) begin
                if (settle_now == '0) begin
                    settle_q <= '0;
                end else begin
                    settle_q <= settle_now - skip_t'(1);
                end
            end
            acc_q <= acc_d;
        end
    end

    // The sum of the finished period is presented in the dump cycle itself.
    assign o_res = '{valid: dump, value: acc_q};

    // Dropping enable throws away the open period, also in the cycle after.
    a_no_result_when_off: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_cfg.enable |-> !o_res.valid ##1 !o_res.valid
    );

endmodule

/* hw/mod_square_gen.sv */
// Square-wave bias generator
module mod_square_gen (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mod_pkg::mod_cfg_t   i_cfg,
    output mod_pkg::mod_phase_t o_phase,
    output mod_pkg::amp_t       o_dac
);
    import mod_pkg::*;

    gen_state_t state_q;
    gen_state_t state_d;
    hperiod_t   cnt_q;
    hperiod_t   cnt_d;
    logic       level_d;
    logic       step_d;
    amp_t       amp_high_q;
    amp_t       amp_low_q;
    amp_t       dac_d;
    mod_phase_t phase_q;
    amp_t       dac_q;

    // The DAC mux works from a registered copy of both levels.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            amp_high_q <= '0;
            amp_low_q  <= '0;
        end else begin
            amp_high_q <= i_cfg.amp_high;
            amp_low_q  <= i_cfg.amp_low;
        end
    end

    // Each phase counts half_period down to zero, then reloads and flips.
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        level_d = phase_q.level;
        step_d  = 1'b0;
        if (!i_cfg.enable) begin
            state_d = GEN_IDLE;
            cnt_d   = '0;
            level_d = 1'b0;
        end else begin
            case (state_q)
                GEN_IDLE: begin
                    state_d = GEN_LOW;
                    cnt_d   = i_cfg.half_period;
                    level_d = 1'b0;
                    step_d  = 1'b1;
                end
                GEN_LOW, GEN_HIGH: begin
                    if (cnt_q == '0) begin
                        state_d = (state_q == GEN_LOW) ? GEN_HIGH : GEN_LOW;
                        cnt_d   = i_cfg.half_period;
                        level_d = (state_q == GEN_LOW);
                        step_d  = 1'b1;
                    end else begin
                        cnt_d = cnt_q - hperiod_t'(1);
                    end
                end
                default: state_d = GEN_IDLE;
            endcase
        end
        dac_d = level_d ? amp_high_q : amp_low_q;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= GEN_IDLE;
            cnt_q   <= '0;
            phase_q <= '0;
            dac_q   <= '0;
        end else begin
            state_q       <= state_d;
            cnt_q         <= cnt_d;
            phase_q.level <= level_d;
            phase_q.step  <= step_d;
            dac_q         <= dac_d;
        end
    end

    assign o_phase = phase_q;
    assign o_dac   = dac_q;

    // The enabling step starts a low phase from idle and is the only step
    // without a level change.
    a_step_on_edge: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_phase.step && $past(state_q) != GEN_IDLE) |->
            (o_phase.level != $past(o_phase.level))
    );

    a_idle_when_off: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_cfg.enable |=> (state_q == GEN_IDLE)
    );

endmodule

/* hw/mod_csr.sv */
// Modulator register block
module mod_csr (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  mod_pkg::wb_addr_t   i_wb_adr,
    input  mod_pkg::wb_data_t   i_wb_dat,
    output mod_pkg::wb_data_t   o_wb_dat,
    output logic                o_wb_ack,
    input  mod_pkg::demod_res_t i_res,
    output mod_pkg::mod_cfg_t   o_cfg
);
    import mod_pkg::*;

    logic     req;
    logic     ack_q;
    logic     wr_pend_q;
    wb_addr_t wr_adr_q;
    wb_data_t wr_dat_q;
    wb_data_t rd_data;
    wb_data_t dat_q;

    logic     ctrl_en_q;
    skip_t    ctrl_skip_q;
    hperiod_t half_period_q;
    amp_t     amp_high_q;
    amp_t     amp_low_q;
    acc_t     result_q;
    wb_data_t result_cnt_q;

    // A new request is one that has not been acknowledged yet.
    assign req = i_wb_cyc && i_wb_stb && !ack_q;

    // The write is applied in the ack cycle, so the configuration changes
    // one cycle after ack.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q     <= 1'b0;
            wr_pend_q <= 1'b0;
            dat_q     <= '0;
        end else begin
            ack_q     <= req;
            wr_pend_q <= req && i_wb_we;
            if (req && !i_wb_we) begin
                dat_q <= rd_data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            wr_adr_q <= i_wb_adr;
            wr_dat_q <= i_wb_dat;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctrl_en_q     <= 1'b0;
            ctrl_skip_q   <= '0;
            half_period_q <= '0;
            amp_high_q    <= '0;
            amp_low_q     <= '0;
        end else if (wr_pend_q) begin
            case (wr_adr_q)
                REG_CTRL: begin
                    ctrl_en_q   <= wr_dat_q[CTRL_EN_BIT];
                    ctrl_skip_q <= wr_dat_q[CTRL_SKIP_MSB:CTRL_SKIP_LSB];
                end
                REG_HPERIOD:  half_period_q <= wr_dat_q[HPERIOD_W-1:0];
                REG_AMP_HIGH: amp_high_q    <= wr_dat_q[AMP_W-1:0];
                REG_AMP_LOW:  amp_low_q     <= wr_dat_q[AMP_W-1:0];
                // Result registers and holes in the map drop the write.
                default: ;
            endcase
        end
    end

    // Result capture and the result counter, which restarts with enable.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            result_q     <= '0;
            result_cnt_q <= '0;
        end else begin
            if (i_res.valid) begin
                result_q <= i_res.value;
            end
            if (!ctrl_en_q) begin
                result_cnt_q <= '0;
            end else if (i_res.valid) begin
                result_cnt_q <= result_cnt_q + wb_data_t'(1);
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (i_wb_adr)
            REG_CTRL: begin
                rd_data[CTRL_EN_BIT]                 = ctrl_en_q;
                rd_data[CTRL_SKIP_MSB:CTRL_SKIP_LSB] = ctrl_skip_q;
            end
            REG_HPERIOD:    rd_data[HPERIOD_W-1:0] = half_period_q;
            REG_AMP_HIGH:   rd_data[AMP_W-1:0]     = amp_high_q;
            REG_AMP_LOW:    rd_data[AMP_W-1:0]     = amp_low_q;
            REG_RESULT:     rd_data                = result_q;
            REG_RESULT_CNT: rd_data                = result_cnt_q;
            default:        rd_data                = '0;
        endcase
    end

    assign o_wb_ack = ack_q;
    assign o_wb_dat = dat_q;

    assign o_cfg = '{
        enable:      ctrl_en_q,
        skip:        ctrl_skip_q,
        half_period: half_period_q,
        amp_high:    amp_high_q,
        amp_low:     amp_low_q
    };

    // Each request gets a single ack even though the master keeps stb high
    // through the ack cycle.
    a_single_ack: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack
    );

endmodule

/* hw/mod_pkg.sv */
// Bias modulator shared definitions
package mod_pkg;

    localparam int AMP_W     = 16;
    localparam int ADC_W     = 16;
    localparam int ACC_W     = 32;
    localparam int HPERIOD_W = 16;
    localparam int SKIP_W    = 8;
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 4;

    // Field positions inside the control word.
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_SKIP_LSB = 8;
    localparam int CTRL_SKIP_MSB = CTRL_SKIP_LSB + SKIP_W - 1;

    typedef logic signed [AMP_W-1:0] amp_t;
    typedef logic signed [ADC_W-1:0] adc_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [HPERIOD_W-1:0]    hperiod_t;
    typedef logic [SKIP_W-1:0]       skip_t;
    typedef logic [WB_DATA_W-1:0]    wb_data_t;
    typedef logic [WB_ADDR_W-1:0]    wb_addr_t;

    localparam wb_addr_t REG_CTRL       = 4'd0;
    localparam wb_addr_t REG_HPERIOD    = 4'd1;
    localparam wb_addr_t REG_AMP_HIGH   = 4'd2;
    localparam wb_addr_t REG_AMP_LOW    = 4'd3;
    localparam wb_addr_t REG_RESULT     = 4'd4;
    localparam wb_addr_t REG_RESULT_CNT = 4'd5;

    typedef struct packed {
        logic     enable;
        skip_t    skip;
        hperiod_t half_period;
        amp_t     amp_high;
        amp_t     amp_low;
    } mod_cfg_t;

    typedef struct packed {
        logic level;
        logic step;
    } mod_phase_t;

    typedef struct packed {
        logic valid;
        acc_t value;
    } demod_res_t;

    typedef enum logic [1:0] {GEN_IDLE, GEN_LOW, GEN_HIGH} gen_state_t;

endpackage
